// ==== src.f ====
hdl/fe_cfg_pkg.sv
hdl/rv_isa_pkg.sv
hdl/bypass_fifo.sv
hdl/pre_decode.sv
hdl/instr_queue.sv
hdl/pc_gen.sv
hdl/frontend_top.sv
sim/frontend_tb.sv

// ==== sim/frontend_tb.sv ====
//################################################
// fetch front end testbench
// random-latency memory, mixed rvi/rvc program,
// back-pressure, flushes, reference next-pc walk
//################################################

`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

	import fe_cfg_pkg::*;

	localparam logic [63:0] BASE = 64'h8000_0000;
	localparam int N_INSTR = 300;
	localparam int LIMIT = N_INSTR * 40 + 500;  // cycles
	localparam int K_SEQ = 0, K_JAL = 1, K_BR = 2, K_JALR = 3, K_RET = 4;

	logic CLK, rst_n_i, flush_i, imem_valid_i, dec_ready_i;
	logic [63:0] flush_pc_i, imem_pc_i, imem_data_i;
	logic imem_req_o, dec_valid_o, dec_is_rvc_o;
	logic [63:0] imem_addr_o, dec_pc_o;
	logic [31:0] dec_instr_o;

	logic [15:0] prog [0:255];    // program halfwords
	int          kind_m [0:255];  // control-flow class per halfword
	logic [63:0] imm_m [0:255];
	bit          call_m [0:255];

	logic [63:0] rras [0:3];  // reference return stack
	int rptr, rcnt;
	logic [63:0] exp_pc;
	string exp_test;
	int errors, xfers, flushes, cycles;
	logic [31:0] rng_mem, rng_stim;
	bit mem_busy, first_req;
	int mem_wait;
	logic [63:0] mem_addr;
	bit stall_phase;
	int flush_state;

	frontend_top i_frontend_top (
		.CLK (CLK), .rst_n_i (rst_n_i), .flush_i (flush_i), .flush_pc_i (flush_pc_i),
		.imem_req_o (imem_req_o), .imem_addr_o (imem_addr_o),
		.imem_valid_i (imem_valid_i), .imem_pc_i (imem_pc_i), .imem_data_i (imem_data_i),
		.dec_valid_o (dec_valid_o), .dec_ready_i (dec_ready_i), .dec_instr_o (dec_instr_o),
		.dec_pc_o (dec_pc_o), .dec_is_rvc_o (dec_is_rvc_o)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// halfword at a byte address
	function automatic logic [15:0] hw(input logic [63:0] a);
		if (a >= BASE && a < BASE + 512) begin
			return prog[(a - BASE) >> 1];
		end
		// quadrant-0 fill folded from the halfword address
		return {a[14:1] ^ a[28:15] ^ a[42:29] ^ a[56:43] ^ {7'd0, a[63:57]}, 2'b00};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] o);
		return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
	endfunction
	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'd0, rs1, 3'b000, rd, 7'b1100111};
	endfunction
	function automatic logic [31:0] enc_beq(input logic [12:0] o);
		return {o[12], o[10:5], 5'd0, 5'd0, 3'b000, o[4:1], o[11], 7'b1100011};
	endfunction
	function automatic logic [15:0] enc_cj(input logic [2:0] f3, input logic [11:0] o);
		return {f3, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
	endfunction
	function automatic logic [15:0] enc_cb(input logic [8:0] o);
		return {3'b110, o[8], o[4:3], 3'b000, o[7:6], o[2:1], o[5], 2'b01};
	endfunction
	function automatic logic [15:0] enc_cr(input bit link, input logic [4:0] rs1);
		return {3'b100, link, rs1, 5'd0, 2'b10};
	endfunction

	task automatic put_rvi(input int a, input logic [31:0] ins, input int k,
		input logic [63:0] imm, input bit call);
		prog[a/2]   = ins[15:0];
		prog[a/2+1] = ins[31:16];
		kind_m[a/2] = k;
		imm_m[a/2]  = imm;
		call_m[a/2] = call;
	endtask

	task automatic put_rvc(input int a, input logic [15:0] ins, input int k,
		input logic [63:0] imm, input bit call);
		prog[a/2]   = ins;
		kind_m[a/2] = k;
		imm_m[a/2]  = imm;
		call_m[a/2] = call;
	endtask

	task automatic build_program;
		logic [31:0] addi;
		logic [15:0] caddi;
		addi  = {12'd1, 5'd2, 3'b000, 5'd2, 7'b0010011};
		caddi = {3'b000, 1'b0, 5'd10, 5'd1, 2'b01};
		for (int i = 0; i < 256; i++) begin
			prog[i]   = {6'd0, i[7:0], 2'b00};
			kind_m[i] = K_SEQ;
			imm_m[i]  = '0;
			call_m[i] = 0;
		end
		put_rvi('h00, addi, K_SEQ, 0, 0);
		put_rvc('h04, caddi, K_SEQ, 0, 0);
		put_rvi('h06, addi, K_SEQ, 0, 0);             // straddles a word
		put_rvc('h0A, caddi, K_SEQ, 0, 0);
		put_rvi('h0C, enc_beq(13'd12), K_BR, 12, 0);  // forward branch falls through
		put_rvi('h10, enc_jalr(5'd0, 5'd6), K_JALR, 0, 0);
		put_rvc('h14, enc_cr(0, 5'd7), K_JALR, 0, 0);
		put_rvc('h16, enc_cb(9'd6), K_BR, 6, 0);
		put_rvi('h18, enc_jal(5'd0, 21'h28), K_JAL, 'h28, 0);
		put_rvc('h30, enc_cj(3'b101, 12'h20), K_JAL, 'h20, 0);
		put_rvc('h40, enc_cb(-9'sd16), K_BR, -64'sd16, 0);  // backward branch taken
		put_rvi('h50, enc_jal(5'd1, 21'hB0), K_JAL, 'hB0, 1);
		put_rvc('h54, enc_cj(3'b001, 12'hCC), K_JAL, 'hCC, 1);
		put_rvi('h56, enc_jalr(5'd5, 5'd9), K_JALR, 0, 1);
		put_rvc('h5A, enc_cr(1, 5'd11), K_JALR, 0, 1);
		put_rvi('h5C, enc_jal(5'd0, -21'sh5C), K_JAL, -64'sh5C, 0);
		// nested subroutines four deep
		put_rvi('h100, addi, K_SEQ, 0, 0);
		put_rvi('h104, enc_jal(5'd1, 21'h3C), K_JAL, 'h3C, 1);
		put_rvi('h108, enc_jalr(5'd0, 5'd1), K_RET, 0, 0);
		put_rvc('h120, caddi, K_SEQ, 0, 0);
		put_rvc('h122, enc_cr(0, 5'd1), K_RET, 0, 0);
		put_rvi('h140, enc_jal(5'd5, 21'h20), K_JAL, 'h20, 1);
		put_rvc('h144, enc_cr(0, 5'd1), K_RET, 0, 0);
		put_rvi('h160, enc_jal(5'd1, 21'h20), K_JAL, 'h20, 1);
		put_rvi('h164, enc_jalr(5'd0, 5'd5), K_RET, 0, 0);
		put_rvc('h180, caddi, K_SEQ, 0, 0);
		put_rvc('h182, enc_cr(0, 5'd5), K_RET, 0, 0);
	endtask

	// next expected pc by the static prediction rules
	task automatic advance_ref;
		int i;
		logic [63:0] nxt, link;
		i = (exp_pc - BASE) >> 1;
		link = exp_pc + ((hw(exp_pc) & 16'h3) != 3 ? 2 : 4);
		nxt = link;
		if (call_m[i] || kind_m[i] == K_RET) begin
			exp_test = "call_return";
		end else if (kind_m[i] == K_SEQ) begin
			exp_test = "sequential";
		end else begin
			exp_test = "control_flow";
		end
		if (kind_m[i] == K_JAL || (kind_m[i] == K_BR && imm_m[i][63])) begin
			nxt = exp_pc + imm_m[i];
		end else if (kind_m[i] == K_RET && rcnt > 0) begin
			rptr = (rptr + 3) % 4;
			nxt = rras[rptr];
			rcnt--;
		end
		if (call_m[i]) begin
			rras[rptr] = link;
			rptr = (rptr + 1) % 4;  // wraps over the oldest
			if (rcnt < 4) rcnt++;
		end
		exp_pc = nxt;
	endtask

	task automatic report_value(input string name, input logic [63:0] e, input logic [63:0] a);
		errors++;
		$display("ERROR %s: expected %h actual %h", name, e, a);
	endtask

	initial begin
		CLK = 0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) cycles <= cycles + 1;

	// memory model with one request in flight
	// answers 1 to 3 cycles after the request cycle
	always @(posedge CLK) begin
		logic [63:0] ra;
		logic [63:0] wa;
		bit          answer;
		answer = 0;
		ra = mem_addr;
		imem_valid_i <= 0;
		if (mem_busy) begin
			if (mem_wait == 1) begin
				answer = 1;
				mem_busy <= 0;
			end else begin
				mem_wait <= mem_wait - 1;
			end
		end
		if (rst_n_i && imem_req_o) begin
			assert (!mem_busy) else begin
				errors++;
				$display("second fetch request issued while one was outstanding");
			end
			if (first_req) begin
				assert (imem_addr_o == RESET_PC)
					else report_value("reset_pc", RESET_PC, imem_addr_o);
				first_req <= 0;
			end
			rng_mem = xorshift(rng_mem);
			if (rng_mem % 3 == 0) begin
				answer = 1;  // right in the next cycle
				ra = imem_addr_o;
			end else begin
				mem_busy <= 1;
				mem_wait <= rng_mem % 3;
				mem_addr <= imem_addr_o;
			end
		end
		if (answer) begin
			wa = ra & ~64'h3;
			imem_valid_i <= 1;
			imem_pc_i    <= ra;
			imem_data_i  <= {hw(wa + 6), hw(wa + 4), hw(wa + 2), hw(wa)};
		end
	end

	// decoder side checks against the reference walk
	always @(posedge CLK) begin
		logic [15:0] h0;
		if (rst_n_i) begin
			if (dec_valid_o && dec_ready_i) begin
				h0 = hw(exp_pc);
				assert (dec_pc_o == exp_pc) else report_value(exp_test, exp_pc, dec_pc_o);
				assert (dec_instr_o == {hw(exp_pc + 2), h0})
					else report_value(exp_test, {hw(exp_pc + 2), h0}, dec_instr_o);
				assert (dec_is_rvc_o == (h0[1:0] != 2'b11))
					else report_value(exp_test, h0[1:0] != 2'b11, dec_is_rvc_o);
				xfers <= xfers + 1;
				advance_ref();
			end
			if (flush_i) begin
				exp_pc = flush_pc_i;  // rebase the walk
				exp_test = "flush";
				flushes++;
			end
		end
	end

	property dec_hold;
		@(posedge CLK) disable iff (!rst_n_i)
		(dec_valid_o && !dec_ready_i && !flush_i) |=> (dec_valid_o && $stable(dec_pc_o)
			&& $stable(dec_instr_o) && $stable(dec_is_rvc_o));
	endproperty
	assert property (dec_hold) else begin
		errors++;
		$display("decoder outputs changed while the decoder was stalled");
	end

	initial begin
		rst_n_i = 0;
		flush_i = 0;
		flush_pc_i = '0;
		dec_ready_i = 0;
		imem_valid_i = 0;
		imem_pc_i = '0;
		imem_data_i = '0;
		errors = 0;
		xfers = 0;
		flushes = 0;
		cycles = 0;
		rng_mem = 32'h54b2;
		rng_stim = 32'h54b2 ^ 32'h9e37_79b9;  // separate stream for stimulus
		mem_busy = 0;
		mem_wait = 0;
		first_req = 1;
		flush_state = 0;
		rptr = 0;
		rcnt = 0;
		exp_pc = RESET_PC;
		exp_test = "sequential";
		build_program();
		repeat (2) @(posedge CLK);
		assert (!dec_valid_o && !imem_req_o) else begin
			errors++;
			$display("dec_valid_o or imem_req_o high during reset");
		end
		rst_n_i <= 1;
		while (xfers < N_INSTR && cycles < LIMIT) begin
			@(posedge CLK);
			rng_stim = xorshift(rng_stim);
			if (cycles % 32 == 0) stall_phase = rng_stim[8];
			flush_i <= 0;
			dec_ready_i <= stall_phase ? rng_stim[0] : (rng_stim[2:0] != 0);
			// a held instruction means the next fetch is not issued yet
			if (flush_state == 0 && xfers >= 80 && !mem_busy && !imem_req_o
				&& dec_valid_o && !dec_ready_i) begin
				flush_i <= 1;  // nothing in flight
				flush_pc_i <= BASE + 'h06;
				dec_ready_i <= 0;
				flush_state = 1;
			end else if (flush_state == 1 && xfers >= 160 && mem_busy && mem_wait >= 2) begin
				flush_i <= 1;  // owed response must be dropped
				flush_pc_i <= BASE + 'h54;
				dec_ready_i <= 0;
				flush_state = 2;
			end
		end
		if (cycles >= LIMIT) begin
			errors++;
			$display("timeout after %0d cycles with %0d instructions seen", cycles, xfers);
		end
		if (flush_state != 2) begin
			errors++;
			$display("not every flush case was reached");
		end
		$display("errors %0d, instructions %0d, flushes %0d, cycles %0d",
			errors, xfers, flushes, cycles);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/frontend_top.sv ====
//################################################
// fetch front end top
// pc generator and instruction queue between
// instruction memory and decoder
//################################################

`timescale 1ns/1ps
`default_nettype none

module frontend_top (
	input  wire                             CLK,
	input  wire                             rst_n_i,
	input  wire                             flush_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     flush_pc_i,

	output logic                            imem_req_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     imem_addr_o,
	input  wire                             imem_valid_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     imem_pc_i,
	input  wire  [fe_cfg_pkg::FETCH_W-1:0]  imem_data_i,

	output logic                            dec_valid_o,
	input  wire                             dec_ready_i,
	output logic [fe_cfg_pkg::ILEN-1:0]     dec_instr_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     dec_pc_o,
	output logic                            dec_is_rvc_o
);

	import fe_cfg_pkg::*;

	logic               fetch_ready;
	logic               resp_valid;
	logic [XLEN-1:0]    resp_pc;
	logic [FETCH_W-1:0] resp_data;
	logic               retire_valid;
	logic [XLEN-1:0]    retire_pc;
	logic               retire_jal;
	logic               retire_jalr;
	logic               retire_branch;
	logic               retire_call;
	logic               retire_ret;
	logic               retire_rvc;
	logic [XLEN-1:0]    retire_imm;

	pc_gen i_pc_gen (
		.CLK (CLK), .rst_n_i (rst_n_i), .flush_i (flush_i), .flush_pc_i (flush_pc_i),
		.fetch_ready_i (fetch_ready),
		.retire_valid_i (retire_valid), .retire_pc_i (retire_pc),
		.retire_jal_i (retire_jal), .retire_jalr_i (retire_jalr),
		.retire_branch_i (retire_branch), .retire_call_i (retire_call),
		.retire_ret_i (retire_ret), .retire_rvc_i (retire_rvc), .retire_imm_i (retire_imm),
		.imem_req_o (imem_req_o), .imem_addr_o (imem_addr_o),
		.imem_valid_i (imem_valid_i), .imem_pc_i (imem_pc_i), .imem_data_i (imem_data_i),
		.resp_valid_o (resp_valid), .resp_pc_o (resp_pc), .resp_data_o (resp_data)
	);

	instr_queue i_instr_queue (
		.CLK (CLK), .rst_n_i (rst_n_i), .flush_i (flush_i),
		.resp_valid_i (resp_valid), .resp_pc_i (resp_pc), .resp_data_i (resp_data),
		.fetch_ready_o (fetch_ready),
		.dec_valid_o (dec_valid_o), .dec_ready_i (dec_ready_i), .dec_instr_o (dec_instr_o),
		.dec_pc_o (dec_pc_o), .dec_is_rvc_o (dec_is_rvc_o),
		.retire_valid_o (retire_valid), .retire_pc_o (retire_pc),
		.retire_jal_o (retire_jal), .retire_jalr_o (retire_jalr),
		.retire_branch_o (retire_branch), .retire_call_o (retire_call),
		.retire_ret_o (retire_ret), .retire_rvc_o (retire_rvc), .retire_imm_o (retire_imm)
	);

endmodule

`default_nettype wire

// ==== hdl/pc_gen.sv ====
//################################################
// pc generator
// static next-pc prediction with a return stack,
// one outstanding fetch, stale response filter
//################################################

`timescale 1ns/1ps
`default_nettype none

module pc_gen (
	input  wire                             CLK,
	input  wire                             rst_n_i,
	input  wire                             flush_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     flush_pc_i,
	input  wire                             fetch_ready_i,

	input  wire                             retire_valid_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     retire_pc_i,
	input  wire                             retire_jal_i,
	input  wire                             retire_jalr_i,
	input  wire                             retire_branch_i,
	input  wire                             retire_call_i,
	input  wire                             retire_ret_i,
	input  wire                             retire_rvc_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     retire_imm_i,

	output logic                            imem_req_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     imem_addr_o,
	input  wire                             imem_valid_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     imem_pc_i,
	input  wire  [fe_cfg_pkg::FETCH_W-1:0]  imem_data_i,

	output logic                            resp_valid_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     resp_pc_o,
	output logic [fe_cfg_pkg::FETCH_W-1:0]  resp_data_o
);

	import fe_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic [XLEN-1:0]      pc_q;       // next fetch pc
	logic                 req_q;      // request on the bus this cycle
	logic                 pend_q;     // fetch waiting to go out
	logic                 outst_q;    // response still owed
	logic                 stale_q;    // owed response belongs to flushed path
	logic [XLEN-1:0]      ras_q [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] ras_ptr_q;  // next free slot
	logic [RAS_PTR_W-1:0] ras_top;
	logic [RAS_PTR_W:0]   ras_cnt_q;  // valid entries, saturates
	logic                 ras_empty;
	logic                 ras_full;
	logic [2:0]           seq_len;
	logic [XLEN-1:0]      seq_pc;
	logic [XLEN-1:0]      pred_pc;
	logic [XLEN-1:0]      tgt_pc;
	logic                 push;
	logic                 pop;
	logic                 drop;
	logic                 slot_free;
	logic                 want;
	logic                 go;

	assign ras_top   = ras_ptr_q - 1'b1;
	assign ras_empty = (ras_cnt_q == '0);
	assign ras_full  = (ras_cnt_q == (RAS_PTR_W+1)'(RAS_DEPTH));

	assign seq_len = retire_rvc_i ? LEN_RVC : LEN_RVI;
	assign seq_pc  = retire_pc_i + {{(XLEN-3){1'b0}}, seq_len};  // fall-through / link

	assign push = retire_valid_i & retire_call_i & ~flush_i;
	assign pop  = retire_valid_i & retire_jalr_i & retire_ret_i & ~ras_empty & ~flush_i;

	always_comb begin
		pred_pc = seq_pc;
		if (retire_jal_i || (retire_branch_i && retire_imm_i[XLEN-1])) begin
			pred_pc = retire_pc_i + retire_imm_i;  // jal or backward branch
		end else if (pop) begin
			pred_pc = ras_q[ras_top];
		end
	end

	// flush beats retire beats hold
	assign tgt_pc = flush_i ? flush_pc_i : (retire_valid_i ? pred_pc : pc_q);

	assign drop      = imem_valid_i & stale_q;
	assign slot_free = ~outst_q | imem_valid_i;
	assign want      = flush_i | retire_valid_i | pend_q;
	assign go        = want & slot_free & (fetch_ready_i | flush_i | drop);  // redirects skip backpressure

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			pc_q    <= RESET_PC;
			req_q   <= 1'b0;
			pend_q  <= 1'b1;  // boot fetch
			outst_q <= 1'b0;
			stale_q <= 1'b0;
		end else begin
			pc_q    <= tgt_pc;
			req_q   <= go;
			pend_q  <= want & ~go;
			outst_q <= go | (outst_q & ~imem_valid_i);
			stale_q <= outst_q & ~imem_valid_i & (stale_q | flush_i);
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			ras_ptr_q <= '0;
			ras_cnt_q <= '0;
		end else if (push) begin
			ras_ptr_q <= ras_ptr_q + 1'b1;  // wraps, oldest entry lost
			if (!ras_full) begin
				ras_cnt_q <= ras_cnt_q + 1'b1;
			end
		end else if (pop) begin
			ras_ptr_q <= ras_top;
			ras_cnt_q <= ras_cnt_q - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			ras_q[ras_ptr_q] <= seq_pc;
		end
	end

	assign imem_req_o  = req_q;
	assign imem_addr_o = pc_q;  // pc_q equals the issued address while req_q is high

	assign resp_valid_o = imem_valid_i & ~stale_q;
	assign resp_pc_o    = imem_pc_i;
	assign resp_data_o  = imem_data_i;

endmodule

`default_nettype wire

// ==== hdl/instr_queue.sv ====
//################################################
// instruction queue
// aligns the fetched window, predecodes it and
// registers the result toward the decoder
//################################################

`timescale 1ns/1ps
`default_nettype none

module instr_queue (
	input  wire                             CLK,
	input  wire                             rst_n_i,
	input  wire                             flush_i,

	input  wire                             resp_valid_i,
	input  wire  [fe_cfg_pkg::XLEN-1:0]     resp_pc_i,
	input  wire  [fe_cfg_pkg::FETCH_W-1:0]  resp_data_i,
	output logic                            fetch_ready_o,

	output logic                            dec_valid_o,
	input  wire                             dec_ready_i,
	output logic [fe_cfg_pkg::ILEN-1:0]     dec_instr_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     dec_pc_o,
	output logic                            dec_is_rvc_o,

	output logic                            retire_valid_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     retire_pc_o,
	output logic                            retire_jal_o,
	output logic                            retire_jalr_o,
	output logic                            retire_branch_o,
	output logic                            retire_call_o,
	output logic                            retire_ret_o,
	output logic                            retire_rvc_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     retire_imm_o
);

	import fe_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic               fifo_empty;
	logic               fifo_valid;
	logic [BYP_W-1:0]   fifo_data;
	logic [XLEN-1:0]    win_pc;
	logic [FETCH_W-1:0] win;
	logic [ILEN-1:0]    align_instr;
	logic               is_rvc;
	logic               pd_jal;
	logic               pd_jalr;
	logic               pd_branch;
	logic               pd_call;
	logic               pd_ret;
	logic [XLEN-1:0]    pd_imm;
	logic [XLEN-1:0]    pc_q;
	logic               rvc_q;

	bypass_fifo i_bypass_fifo (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.flush_i (flush_i),
		.valid_i (resp_valid_i),
		.data_i  ({resp_pc_i, resp_data_i}),
		.empty_o (fifo_empty),
		.valid_o (fifo_valid),
		.data_o  (fifo_data),
		.ready_i (dec_ready_i)
	);

	assign fetch_ready_o = fifo_empty & dec_ready_i;  // room for the next window

	assign win_pc = fifo_data[BYP_W-1 -: XLEN];
	assign win    = fifo_data[FETCH_W-1:0];

	// window starts word aligned, pc[1] picks the upper halfword start
	assign align_instr = win_pc[1] ? win[16 +: ILEN] : win[0 +: ILEN];
	assign is_rvc      = (align_instr[1:0] != QUAD_RVI);

	pre_decode i_pre_decode (
		.instr_i  (align_instr),
		.is_rvc_i (is_rvc),
		.jal_o    (pd_jal),
		.jalr_o   (pd_jalr),
		.branch_o (pd_branch),
		.call_o   (pd_call),
		.ret_o    (pd_ret),
		.imm_o    (pd_imm)
	);

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			dec_valid_o <= 1'b0;
		end else if (flush_i) begin
			dec_valid_o <= 1'b0;  // kill whatever sits at the decoder
		end else if (dec_ready_i) begin
			dec_valid_o <= fifo_valid;
		end
	end

	// payload moves only when the decoder takes, so it holds under stall
	always_ff @(posedge CLK) begin
		if (dec_ready_i) begin
			dec_instr_o     <= align_instr;
			pc_q            <= win_pc;
			rvc_q           <= is_rvc;
			retire_jal_o    <= pd_jal;
			retire_jalr_o   <= pd_jalr;
			retire_branch_o <= pd_branch;
			retire_call_o   <= pd_call;
			retire_ret_o    <= pd_ret;
			retire_imm_o    <= pd_imm;
		end
	end

	assign dec_pc_o     = pc_q;
	assign dec_is_rvc_o = rvc_q;

	// one strobe per decoder transfer
	assign retire_valid_o = dec_valid_o & dec_ready_i;
	assign retire_pc_o    = pc_q;
	assign retire_rvc_o   = rvc_q;

endmodule

`default_nettype wire

// ==== hdl/pre_decode.sv ====
//################################################
// control-flow predecode
// spots jal, jalr, branches, calls and returns in
// rvi and rvc form and builds the offset
//################################################

`timescale 1ns/1ps
`default_nettype none

module pre_decode (
	input  wire  [fe_cfg_pkg::ILEN-1:0]     instr_i,
	input  wire                             is_rvc_i,

	output logic                            jal_o,
	output logic                            jalr_o,
	output logic                            branch_o,
	output logic                            call_o,
	output logic                            ret_o,
	output logic [fe_cfg_pkg::XLEN-1:0]     imm_o
);

	import fe_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic [6:0]      opc;
	logic [4:0]      rd;
	logic [4:0]      rs1;
	logic [1:0]      c_quad;
	logic [2:0]      c_f3;
	logic [4:0]      c_rs1;      // also rd for cr format
	logic [4:0]      c_rs2;
	logic            i_jal;
	logic            i_jalr;
	logic            i_br;
	logic            c_j;
	logic            c_jal;
	logic            c_jr;
	logic            c_jalr;
	logic            c_br;
	logic            cr_jump;    // c.jr / c.jalr shared pattern
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_cj;
	logic [XLEN-1:0] imm_cb;

	function automatic logic is_link(input logic [4:0] r);
		return (r == REG_RA) || (r == REG_T0);
	endfunction

	// field extraction
	assign opc    = instr_i[6:0];
	assign rd     = instr_i[11:7];
	assign rs1    = instr_i[19:15];
	assign c_quad = instr_i[1:0];
	assign c_f3   = instr_i[15:13];
	assign c_rs1  = instr_i[11:7];
	assign c_rs2  = instr_i[6:2];

	// full-size forms
	assign i_jal  = ~is_rvc_i & (opc == OPC_JAL);
	assign i_jalr = ~is_rvc_i & (opc == OPC_JALR);
	assign i_br   = ~is_rvc_i & (opc == OPC_BRANCH);

	// compressed forms
	assign c_j   = is_rvc_i & (c_quad == C_Q1) & (c_f3 == C_OP_J);
	assign c_jal = is_rvc_i & (c_quad == C_Q1) & (c_f3 == C_OP_JAL);
	assign c_br  = is_rvc_i & (c_quad == C_Q1)
		& ((c_f3 == C_OP_BEQZ) | (c_f3 == C_OP_BNEZ));

	// rs2 == 0 and rs1 != 0, otherwise mv/add/ebreak
	assign cr_jump = is_rvc_i & (c_quad == C_Q2) & (c_f3 == C_OP_JR)
		& (c_rs2 == REG_ZERO) & (c_rs1 != REG_ZERO);
	assign c_jr   = cr_jump & ~instr_i[12];
	assign c_jalr = cr_jump &  instr_i[12];  // links to ra

	// sign-extended offsets
	assign imm_j  = {{44{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
	assign imm_b  = {{52{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_cj = {{52{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
		instr_i[7], instr_i[2], instr_i[11], instr_i[5:3], 1'b0};
	assign imm_cb = {{55{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
		instr_i[11:10], instr_i[4:3], 1'b0};

	assign jal_o    = i_jal | c_j | c_jal;
	assign jalr_o   = i_jalr | c_jr | c_jalr;
	assign branch_o = i_br | c_br;

	// calls write a link reg, c.jal and c.jalr always write ra
	assign call_o = ((i_jal | i_jalr) & is_link(rd)) | c_jal | c_jalr;

	// return reads a link reg and writes none
	assign ret_o = (i_jalr & is_link(rs1) & ~is_link(rd)) | (c_jr & is_link(c_rs1));

	always_comb begin
		if (is_rvc_i) begin
			imm_o = c_br ? imm_cb : imm_cj;
		end else begin
			imm_o = i_br ? imm_b : imm_j;  // jalr target not predicted
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bypass_fifo.sv ====
//################################################
// single-entry bypass fifo
// passes data through when empty and the consumer
// is ready, otherwise holds it until taken
//################################################

`timescale 1ns/1ps
`default_nettype none

module bypass_fifo (
	input  wire                             CLK,
	input  wire                             rst_n_i,
	input  wire                             flush_i,

	input  wire                             valid_i,
	input  wire  [fe_cfg_pkg::BYP_W-1:0]    data_i,
	output logic                            empty_o,

	output logic                            valid_o,
	output logic [fe_cfg_pkg::BYP_W-1:0]    data_o,
	input  wire                             ready_i
);

	import fe_cfg_pkg::*;

	logic             full_q;   // entry occupied
	logic [BYP_W-1:0] data_q;   // held payload
	logic             pass;     // input goes straight out
	logic             store;    // input lands in the entry

	assign pass = ~full_q & ready_i;

	// when full, a new word only fits if the old one leaves this cycle
	// producer never sends into a full, stalled entry
	assign store = valid_i & ~pass & (~full_q | ready_i);

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			full_q <= 1'b0;
		end else if (flush_i) begin
			full_q <= 1'b0;  // drop queued window
		end else if (store) begin
			full_q <= 1'b1;
		end else if (ready_i) begin
			full_q <= 1'b0;  // drained
		end
	end

	always_ff @(posedge CLK) begin
		if (store) begin
			data_q <= data_i;
		end
	end

	assign empty_o = ~full_q;
	assign valid_o = full_q | valid_i;
	assign data_o  = full_q ? data_q : data_i;  // held entry first

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
//################################################
// riscv encodings used by predecode
// major opcodes, rvc quadrants and funct3 codes,
// link registers and instruction lengths
//################################################

`default_nettype none

package rv_isa_pkg;

	// 32-bit major opcodes
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// low two bits, 11 marks a full-size instruction
	localparam logic [1:0] QUAD_RVI = 2'b11;
	localparam logic [1:0] C_Q1     = 2'b01;  // c.j, c.jal, c.beqz, c.bnez
	localparam logic [1:0] C_Q2     = 2'b10;  // c.jr, c.jalr

	// compressed funct3, bits 15:13
	localparam logic [2:0] C_OP_JAL  = 3'b001;  // rv32c slot
	localparam logic [2:0] C_OP_JR   = 3'b100;  // c.jr and c.jalr, split by bit 12
	localparam logic [2:0] C_OP_J    = 3'b101;
	localparam logic [2:0] C_OP_BEQZ = 3'b110;
	localparam logic [2:0] C_OP_BNEZ = 3'b111;

	// registers that matter for call/return detection
	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_RA   = 5'd1;   // x1
	localparam logic [4:0] REG_T0   = 5'd5;   // x5, alternate link

	// instruction lengths in bytes
	localparam logic [2:0] LEN_RVI = 3'd4;
	localparam logic [2:0] LEN_RVC = 3'd2;

endpackage

`default_nettype wire

// ==== hdl/fe_cfg_pkg.sv ====
//################################################
// front-end configuration
// pc and fetch window widths, reset pc and
// return-address stack sizing
//################################################

`default_nettype none

package fe_cfg_pkg;

	localparam int unsigned XLEN    = 64;  // pc width
	localparam int unsigned FETCH_W = 64;  // memory response window
	localparam int unsigned ILEN    = 32;  // widest aligned instruction

	// bypass fifo entry holds pc plus window
	localparam int unsigned BYP_W = XLEN + FETCH_W;

	// first fetch after reset
	localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

	// return-address stack
	localparam int unsigned RAS_DEPTH = 4;
	localparam int unsigned RAS_PTR_W = $clog2(RAS_DEPTH);  // 2 for four entries

endpackage

`default_nettype wire
